// File: hdl/exmem_pkg.sv
// Execute and memory stage types
package exmem_pkg;

    // Data RAM word address width.
    localparam int RAM_AW = 6;
    localparam int RAM_WORDS = 1 << RAM_AW;

    typedef enum logic [2:0] {
        ALU_NOP,
        ALU_ADD,
        ALU_ADDU,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT
    } alu_op_e;

    // Nine encodings, so four bits.
    typedef enum logic [3:0] {
        MEM_NONE,
        MEM_LW,
        MEM_LH,
        MEM_LHU,
        MEM_LB,
        MEM_LBU,
        MEM_SW,
        MEM_SH,
        MEM_SB
    } mem_op_e;

    typedef enum logic [1:0] {
        EXC_NONE,
        EXC_OVF,
        EXC_ADEL,
        EXC_ADES
    } exc_e;

    typedef struct packed {
        logic [31:0] pc;
        alu_op_e     alu_op;
        mem_op_e     mem_op;
        logic [31:0] src_a;
        logic [31:0] src_b;
        logic [31:0] st_data;
        logic        wr_en;
        logic [4:0]  wr_addr;
    } ex_op_t;

    typedef struct packed {
        logic [31:0] pc;
        mem_op_e     mem_op;
        logic [31:0] alures;
        logic [31:0] st_data;
        logic        wr_en;
        logic [4:0]  wr_addr;
        exc_e        excp;
    } ex_mem_t;

    typedef struct packed {
        logic [31:0] pc;
        logic        wr_en;
        logic [4:0]  wr_addr;
        logic [31:0] wr_data;
        exc_e        excp;
    } wb_t;

    typedef union packed {
        logic [31:0]     word;
        logic [3:0][7:0] bytes;
    } data_word_u;

    // Empty EX/MEM slot, pc is filled in by the register.
    localparam ex_mem_t EX_MEM_BUBBLE = '{
        pc:      32'h0,
        mem_op:  MEM_NONE,
        alures:  32'h0,
        st_data: 32'h0,
        wr_en:   1'b0,
        wr_addr: 5'h0,
        excp:    EXC_NONE
    };

endpackage

// File: hdl/pipe_ctrl.sv
// Pipeline stall and exception control
`timescale 1ns/10ps

module pipe_ctrl (
    input  logic                clk,
    input  logic                rst,
    input  logic                mem_wait,
    input  logic                restart,
    input  exmem_pkg::exc_e     mem_exc,
    input  logic [31:0]         mem_pc,
    output logic                stall,
    output logic                flush,
    output logic                exc_pending,
    output logic [31:0]         epc,
    output exmem_pkg::exc_e     cause
);

    logic exc_take;

    // A faulting op is only taken once the memory stage may advance.
    assign exc_take = (mem_exc != exmem_pkg::EXC_NONE) && !stall;
    assign stall = mem_wait;
    assign flush = exc_take || (exc_pending && !restart);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            exc_pending <= 1'b0;
            epc         <= 32'h0;
            cause       <= exmem_pkg::EXC_NONE;
        end else if (exc_take) begin
            exc_pending <= 1'b1;
            epc         <= mem_pc;
            cause       <= mem_exc;
        end else if (restart) begin
            exc_pending <= 1'b0;
        end
    end

    // Only bubbles reach the memory stage while an exception is pending.
    a_pending_bubbles: assert property (@(posedge clk) disable iff (rst)
        exc_pending |-> (mem_exc == exmem_pkg::EXC_NONE));

endmodule

// File: hdl/alu_exec.sv
// Execute stage ALU
`timescale 1ns/10ps

module alu_exec (
    input  exmem_pkg::ex_op_t  ex_op,
    output exmem_pkg::ex_mem_t ex_out
);

    logic [31:0] sum;
    logic [31:0] diff;
    logic        ovf;

    assign sum  = ex_op.src_a + ex_op.src_b;
    assign diff = ex_op.src_a - ex_op.src_b;

    always_comb begin
        ovf            = 1'b0;
        ex_out.pc      = ex_op.pc;
        ex_out.mem_op  = ex_op.mem_op;
        ex_out.st_data = ex_op.st_data;
        ex_out.wr_en   = ex_op.wr_en;
        ex_out.wr_addr = ex_op.wr_addr;
        ex_out.excp    = exmem_pkg::EXC_NONE;

        if (ex_op.mem_op != exmem_pkg::MEM_NONE) begin
            // Effective address.
            ex_out.alures = sum;
        end else begin
            case (ex_op.alu_op)
                exmem_pkg::ALU_ADD: begin
                    ex_out.alures = sum;
                    ovf = (ex_op.src_a[31] == ex_op.src_b[31]) &&
                          (sum[31] != ex_op.src_a[31]);
                end
                exmem_pkg::ALU_ADDU: ex_out.alures = sum;
                exmem_pkg::ALU_SUB: begin
                    ex_out.alures = diff;
                    ovf = (ex_op.src_a[31] != ex_op.src_b[31]) &&
                          (diff[31] != ex_op.src_a[31]);
                end
                exmem_pkg::ALU_AND:  ex_out.alures = ex_op.src_a & ex_op.src_b;
                exmem_pkg::ALU_OR:   ex_out.alures = ex_op.src_a | ex_op.src_b;
                exmem_pkg::ALU_XOR:  ex_out.alures = ex_op.src_a ^ ex_op.src_b;
                exmem_pkg::ALU_SLT: begin
                    ex_out.alures = {31'h0, $signed(ex_op.src_a) < $signed(ex_op.src_b)};
                end
                default: ex_out.alures = 32'h0;
            endcase
        end

        // Trapping op must not write anything.
        if (ovf) begin
            ex_out.excp   = exmem_pkg::EXC_OVF;
            ex_out.wr_en  = 1'b0;
            ex_out.mem_op = exmem_pkg::MEM_NONE;
        end
    end

endmodule

// File: hdl/ex_mem_reg.sv
// EX/MEM pipeline register
`timescale 1ns/10ps

module ex_mem_reg (
    input  logic               clk,
    input  logic               rst,
    input  logic               stall,
    input  logic               flush,
    input  exmem_pkg::ex_mem_t ex_in,
    output exmem_pkg::ex_mem_t mem_stage
);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mem_stage <= exmem_pkg::EX_MEM_BUBBLE;
        end else if (flush) begin
            // Flush wins over stall.
            mem_stage    <= exmem_pkg::EX_MEM_BUBBLE;
            mem_stage.pc <= ex_in.pc;
        end else if (!stall) begin
            mem_stage <= ex_in;
        end
    end

    a_flush_bubble: assert property (@(posedge clk) disable iff (rst)
        flush |=> (mem_stage.mem_op == exmem_pkg::MEM_NONE) &&
                  !mem_stage.wr_en &&
                  (mem_stage.excp == exmem_pkg::EXC_NONE));

endmodule

// File: hdl/mem_access.sv
// Memory stage with MEM/WB register
`timescale 1ns/10ps

module mem_access (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          stall,
    input  exmem_pkg::ex_mem_t            mem_stage,
    output logic [exmem_pkg::RAM_AW-1:0]  ram_addr,
    output logic [3:0]                    ram_be,
    output logic [31:0]                   ram_wdata,
    output logic                          ram_we,
    input  logic [31:0]                   ram_rdata,
    output exmem_pkg::exc_e               mem_exc,
    output logic [31:0]                   mem_pc,
    output exmem_pkg::wb_t                wb
);

    logic [1:0]            off;
    logic                  is_load;
    logic                  is_store;
    logic                  misalign;
    exmem_pkg::data_word_u wdata_u;
    exmem_pkg::data_word_u rdata_u;
    logic [15:0]           half;
    logic [7:0]            byte_val;
    logic [31:0]           load_data;

    assign off      = mem_stage.alures[1:0];
    assign ram_addr = mem_stage.alures[exmem_pkg::RAM_AW+1:2];
    assign mem_pc   = mem_stage.pc;
    assign is_load  = mem_stage.mem_op inside {exmem_pkg::MEM_LW, exmem_pkg::MEM_LH,
        exmem_pkg::MEM_LHU, exmem_pkg::MEM_LB, exmem_pkg::MEM_LBU};
    assign is_store = mem_stage.mem_op inside {exmem_pkg::MEM_SW, exmem_pkg::MEM_SH,
        exmem_pkg::MEM_SB};

    always_comb begin
        case (mem_stage.mem_op)
            exmem_pkg::MEM_LW, exmem_pkg::MEM_SW: misalign = (off != 2'b00);
            exmem_pkg::MEM_LH, exmem_pkg::MEM_LHU, exmem_pkg::MEM_SH: misalign = off[0];
            default: misalign = 1'b0;
        endcase
    end

    // ALU trap first, then address faults.
    always_comb begin
        if (mem_stage.excp != exmem_pkg::EXC_NONE) begin
            mem_exc = mem_stage.excp;
        end else if (misalign && is_load) begin
            mem_exc = exmem_pkg::EXC_ADEL;
        end else if (misalign && is_store) begin
            mem_exc = exmem_pkg::EXC_ADES;
        end else begin
            mem_exc = exmem_pkg::EXC_NONE;
        end
    end

    // Store lanes, little endian.
    always_comb begin
        wdata_u.word = 32'h0;
        ram_be       = 4'b0000;
        case (mem_stage.mem_op)
            exmem_pkg::MEM_SW: begin
                wdata_u.word = mem_stage.st_data;
                ram_be       = 4'b1111;
            end
            exmem_pkg::MEM_SH: begin
                wdata_u.bytes[{off[1], 1'b0}] = mem_stage.st_data[7:0];
                wdata_u.bytes[{off[1], 1'b1}] = mem_stage.st_data[15:8];
                ram_be = off[1] ? 4'b1100 : 4'b0011;
            end
            exmem_pkg::MEM_SB: begin
                wdata_u.bytes[off] = mem_stage.st_data[7:0];
                ram_be = 4'b0001 << off;
            end
            default: ;
        endcase
    end

    assign ram_wdata = wdata_u.word;
    assign ram_we    = is_store && (mem_exc == exmem_pkg::EXC_NONE) && !stall;

    assign rdata_u.word = ram_rdata;
    assign half     = {rdata_u.bytes[{off[1], 1'b1}], rdata_u.bytes[{off[1], 1'b0}]};
    assign byte_val = rdata_u.bytes[off];

    always_comb begin
        case (mem_stage.mem_op)
            exmem_pkg::MEM_LH:  load_data = {{16{half[15]}}, half};
            exmem_pkg::MEM_LHU: load_data = {16'h0, half};
            exmem_pkg::MEM_LB:  load_data = {{24{byte_val[7]}}, byte_val};
            exmem_pkg::MEM_LBU: load_data = {24'h0, byte_val};
            default:            load_data = rdata_u.word;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wb <= '0;
        end else if (!stall) begin
            wb.pc      <= mem_stage.pc;
            wb.wr_en   <= mem_stage.wr_en && (mem_exc == exmem_pkg::EXC_NONE);
            wb.wr_addr <= mem_stage.wr_addr;
            wb.wr_data <= is_load ? load_data : mem_stage.alures;
            wb.excp    <= mem_exc;
        end
    end

    // An ALU trap arrives with no memory access and no register write.
    a_trap_no_access: assert property (@(posedge clk) disable iff (rst)
        (mem_stage.excp != exmem_pkg::EXC_NONE) |->
            (mem_stage.mem_op == exmem_pkg::MEM_NONE) && !mem_stage.wr_en);

endmodule

// File: hdl/data_ram.sv
// Byte-enabled data RAM
`timescale 1ns/10ps

module data_ram (
    input  logic                         clk,
    input  logic [exmem_pkg::RAM_AW-1:0] addr,
    input  logic [3:0]                   be,
    input  logic [31:0]                  wdata,
    input  logic                         we,
    output logic [31:0]                  rdata
);

    logic [31:0] mem [0:exmem_pkg::RAM_WORDS-1] = '{default: 32'h0};

    always_ff @(posedge clk) begin
        if (we) begin
            for (int i = 0; i < 4; i++) begin
                if (be[i]) begin
                    mem[addr][i*8 +: 8] <= wdata[i*8 +: 8];
                end
            end
        end
    end

    // Read is asynchronous.
    assign rdata = mem[addr];

endmodule

// File: hdl/exmem_top.sv
// Execute and memory pipeline slice
`timescale 1ns/10ps

module exmem_top (
    input  logic               clk,
    input  logic               rst,
    input  exmem_pkg::ex_op_t  ex_op,
    input  logic               mem_wait,
    input  logic               restart,
    output exmem_pkg::wb_t     wb,
    output logic               stall,
    output logic               exc_pending,
    output logic [31:0]        epc,
    output exmem_pkg::exc_e    cause
);

    exmem_pkg::ex_mem_t           ex_result;
    exmem_pkg::ex_mem_t           mem_stage;
    logic                         flush;
    logic [exmem_pkg::RAM_AW-1:0] ram_addr;
    logic [3:0]                   ram_be;
    logic [31:0]                  ram_wdata;
    logic                         ram_we;
    logic [31:0]                  ram_rdata;
    exmem_pkg::exc_e              mem_exc;
    logic [31:0]                  mem_pc;

    pipe_ctrl i_pipe_ctrl (
        .clk         (clk),
        .rst         (rst),
        .mem_wait    (mem_wait),
        .restart     (restart),
        .mem_exc     (mem_exc),
        .mem_pc      (mem_pc),
        .stall       (stall),
        .flush       (flush),
        .exc_pending (exc_pending),
        .epc         (epc),
        .cause       (cause)
    );

    alu_exec i_alu_exec (
        .ex_op  (ex_op),
        .ex_out (ex_result)
    );

    ex_mem_reg i_ex_mem_reg (
        .clk       (clk),
        .rst       (rst),
        .stall     (stall),
        .flush     (flush),
        .ex_in     (ex_result),
        .mem_stage (mem_stage)
    );

    mem_access i_mem_access (
        .clk       (clk),
        .rst       (rst),
        .stall     (stall),
        .mem_stage (mem_stage),
        .ram_addr  (ram_addr),
        .ram_be    (ram_be),
        .ram_wdata (ram_wdata),
        .ram_we    (ram_we),
        .ram_rdata (ram_rdata),
        .mem_exc   (mem_exc),
        .mem_pc    (mem_pc),
        .wb        (wb)
    );

    data_ram i_data_ram (
        .clk   (clk),
        .addr  (ram_addr),
        .be    (ram_be),
        .wdata (ram_wdata),
        .we    (ram_we),
        .rdata (ram_rdata)
    );

endmodule

// File: testbench/exmem_tb.sv
// Execute and memory slice testbench
`timescale 1ns/10ps

module exmem_tb;

    logic                clk = 1'b0;
    logic                rst;
    exmem_pkg::ex_op_t   ex_op;
    logic                mem_wait;
    logic                restart;
    exmem_pkg::wb_t      wb;
    logic                stall;
    logic                exc_pending;
    logic [31:0]         epc;
    exmem_pkg::exc_e     cause;

    // Reference model state.
    logic [31:0]         mirror [64] = '{default: 32'h0};
    exmem_pkg::wb_t      expq[$];
    exmem_pkg::wb_t      head;
    logic                squash;
    logic                stall_mode;
    logic                adv;
    logic [31:0]         pc_cnt;
    logic [31:0]         exp_epc;
    exmem_pkg::exc_e     exp_cause;
    int                  errors = 0;
    int                  err_mark = 0;
    int                  pass_cnt = 0;
    int                  fail_cnt = 0;
    int                  cycles = 0;

    exmem_top i_exmem_top (
        .clk         (clk),
        .rst         (rst),
        .ex_op       (ex_op),
        .mem_wait    (mem_wait),
        .restart     (restart),
        .wb          (wb),
        .stall       (stall),
        .exc_pending (exc_pending),
        .epc         (epc),
        .cause       (cause)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles == 3000) begin
            $display("Timeout, the run did not finish within 3000 cycles");
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    // The wb register only moves on edges without stall.
    always @(posedge clk) begin
        adv <= !stall && !rst;
    end

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        assert (act == exp) else begin
            errors++;
            $display("Fail at %0t: %s expected %h, got %h", $time, name, exp, act);
        end
    endtask

    always @(negedge clk) begin
        if (!rst && adv && (wb.wr_en || wb.excp != exmem_pkg::EXC_NONE)) begin
            if (expq.size() == 0) begin
                errors++;
                $display("Unexpected write-back at %0t from pc %h", $time, wb.pc);
            end else begin
                head = expq.pop_front();
                check_value("wb.pc", head.pc, wb.pc);
                check_value("wb.wr_en", 32'(head.wr_en), 32'(wb.wr_en));
                check_value("wb.wr_addr", 32'(head.wr_addr), 32'(wb.wr_addr));
                check_value("wb.excp", 32'(head.excp), 32'(wb.excp));
                if (head.excp == exmem_pkg::EXC_NONE) begin
                    check_value("wb.wr_data", head.wr_data, wb.wr_data);
                end
            end
        end
    end

    function automatic logic [31:0] alu_ref(input exmem_pkg::alu_op_e op,
                                            input logic [31:0] a, input logic [31:0] b);
        case (op)
            exmem_pkg::ALU_ADD, exmem_pkg::ALU_ADDU: return a + b;
            exmem_pkg::ALU_SUB: return a - b;
            exmem_pkg::ALU_AND: return a & b;
            exmem_pkg::ALU_OR:  return a | b;
            exmem_pkg::ALU_XOR: return a ^ b;
            exmem_pkg::ALU_SLT: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            default:            return 32'h0;
        endcase
    endfunction

    // Exact result must fit in 32 signed bits.
    function automatic logic ovf_ref(input exmem_pkg::alu_op_e op,
                                     input logic [31:0] a, input logic [31:0] b);
        longint x;
        longint y;
        longint s;
        x = longint'($signed(a));
        y = longint'($signed(b));
        if (op == exmem_pkg::ALU_ADD) begin
            s = x + y;
        end else if (op == exmem_pkg::ALU_SUB) begin
            s = x - y;
        end else begin
            return 1'b0;
        end
        return s != longint'(int'(s));
    endfunction

    function automatic int access_size(input exmem_pkg::mem_op_e op);
        case (op)
            exmem_pkg::MEM_LW, exmem_pkg::MEM_SW: return 4;
            exmem_pkg::MEM_LH, exmem_pkg::MEM_LHU, exmem_pkg::MEM_SH: return 2;
            default: return 1;
        endcase
    endfunction

    function automatic logic [31:0] load_ref(input exmem_pkg::mem_op_e op,
                                             input logic [31:0] word, input int off);
        logic [31:0] sh;
        sh = word >> (8 * off);
        case (op)
            exmem_pkg::MEM_LH:  return {{16{sh[15]}}, sh[15:0]};
            exmem_pkg::MEM_LHU: return {16'h0, sh[15:0]};
            exmem_pkg::MEM_LB:  return {{24{sh[7]}}, sh[7:0]};
            exmem_pkg::MEM_LBU: return {24'h0, sh[7:0]};
            default:            return word;
        endcase
    endfunction

    function automatic exmem_pkg::ex_op_t rand_alu_op();
        exmem_pkg::ex_op_t op;
        logic [31:0] sel;
        op = '0;
        sel = $urandom_range(0, 7);
        op.alu_op = exmem_pkg::alu_op_e'(sel[2:0]);
        op.src_a = $urandom();
        op.src_b = $urandom();
        // Quarter range operands cannot overflow.
        if (op.alu_op inside {exmem_pkg::ALU_ADD, exmem_pkg::ALU_SUB}) begin
            op.src_a = $signed(op.src_a) >>> 2;
            op.src_b = $signed(op.src_b) >>> 2;
        end
        sel = $urandom();
        op.wr_en = 1'b1;
        op.wr_addr = sel[4:0];
        return op;
    endfunction

    function automatic exmem_pkg::ex_op_t mem_op_at(input exmem_pkg::mem_op_e kind,
                                                    input logic [31:0] addr,
                                                    input logic [31:0] data);
        exmem_pkg::ex_op_t op;
        logic [31:0] sel;
        op = '0;
        op.mem_op = kind;
        op.src_a = $urandom();
        op.src_b = addr - op.src_a;
        op.st_data = data;
        op.wr_en = kind inside {exmem_pkg::MEM_LW, exmem_pkg::MEM_LH, exmem_pkg::MEM_LHU,
                                exmem_pkg::MEM_LB, exmem_pkg::MEM_LBU};
        sel = $urandom();
        op.wr_addr = sel[4:0];
        return op;
    endfunction

    function automatic exmem_pkg::ex_op_t rand_mem_op(input logic store);
        exmem_pkg::mem_op_e kind;
        logic [31:0] sel;
        logic [31:0] addr;
        int n;
        int off;
        int word;
        sel = store ? $urandom_range(6, 8) : $urandom_range(1, 5);
        kind = exmem_pkg::mem_op_e'(sel[3:0]);
        n = access_size(kind);
        off = (n == 4) ? 0 : (n == 2) ? 2 * $urandom_range(0, 1) : $urandom_range(0, 3);
        word = $urandom_range(0, 63);
        addr = ($urandom() & 32'hffffff00) | (word << 2) | off;
        return mem_op_at(kind, addr, $urandom());
    endfunction

    task automatic issue(input exmem_pkg::ex_op_t op_in);
        exmem_pkg::ex_op_t op;
        exmem_pkg::wb_t rec;
        logic [31:0] addr;
        logic ld;
        logic w;
        int n;
        int off;
        op = op_in;
        op.pc = pc_cnt;
        pc_cnt += 4;
        rec = '0;
        rec.pc = op.pc;
        rec.wr_addr = op.wr_addr;
        if (!squash) begin
            if (op.mem_op == exmem_pkg::MEM_NONE) begin
                if (ovf_ref(op.alu_op, op.src_a, op.src_b)) begin
                    rec.excp = exmem_pkg::EXC_OVF;
                end else begin
                    rec.wr_en = op.wr_en;
                    rec.wr_data = alu_ref(op.alu_op, op.src_a, op.src_b);
                end
            end else begin
                addr = op.src_a + op.src_b;
                n = access_size(op.mem_op);
                off = int'(addr[1:0]);
                ld = op.mem_op inside {exmem_pkg::MEM_LW, exmem_pkg::MEM_LH,
                    exmem_pkg::MEM_LHU, exmem_pkg::MEM_LB, exmem_pkg::MEM_LBU};
                if (off % n != 0) begin
                    rec.excp = ld ? exmem_pkg::EXC_ADEL : exmem_pkg::EXC_ADES;
                end else if (ld) begin
                    rec.wr_en = op.wr_en;
                    rec.wr_data = load_ref(op.mem_op, mirror[addr[7:2]], off);
                end else begin
                    for (int i = 0; i < n; i++) begin
                        mirror[addr[7:2]][(off + i) * 8 +: 8] = op.st_data[i * 8 +: 8];
                    end
                end
            end
            if (rec.excp != exmem_pkg::EXC_NONE) begin
                squash = 1'b1;
                exp_epc = op.pc;
                exp_cause = rec.excp;
            end
            if (rec.wr_en || rec.excp != exmem_pkg::EXC_NONE) begin
                expq.push_back(rec);
            end
        end
        ex_op = op;
        // Op is held until an edge without memory wait.
        do begin
            mem_wait = stall_mode && ($urandom_range(0, 2) == 0);
            w = mem_wait;
            #1;
            check_value("stall", 32'(mem_wait), 32'(stall));
            @(negedge clk);
        end while (w);
    endtask

    task automatic drain();
        stall_mode = 1'b0;
        repeat (3) issue('0);
    endtask

    task automatic finish_test(input string name);
        drain();
        if (errors == err_mark) begin
            pass_cnt++;
            $display("Test %s passed", name);
        end else begin
            fail_cnt++;
            $display("Test %s failed with %0d errors", name, errors - err_mark);
        end
        err_mark = errors;
    endtask

    task automatic pulse_restart();
        ex_op = '0;
        mem_wait = 1'b0;
        restart = 1'b1;
        @(negedge clk);
        restart = 1'b0;
        squash = 1'b0;
        check_value("exc_pending", 32'h0, 32'(exc_pending));
    endtask

    task automatic fault_case(input exmem_pkg::ex_op_t op);
        issue(op);
        // These two must be squashed.
        issue(rand_alu_op());
        issue(rand_alu_op());
        drain();
        check_value("exc_pending", 32'h1, 32'(exc_pending));
        check_value("epc", exp_epc, epc);
        check_value("cause", 32'(exp_cause), 32'(cause));
        pulse_restart();
    endtask

    initial begin
        exmem_pkg::ex_op_t op;
        void'($urandom(32'h6922));
        rst = 1'b1;
        ex_op = '0;
        mem_wait = 1'b0;
        restart = 1'b0;
        squash = 1'b0;
        stall_mode = 1'b0;
        pc_cnt = 32'h0040_0000;
        exp_epc = 32'h0;
        exp_cause = exmem_pkg::EXC_NONE;
        repeat (4) @(negedge clk);
        rst = 1'b0;
        check_value("wb.wr_en", 32'h0, 32'(wb.wr_en));
        check_value("wb.excp", 32'h0, 32'(wb.excp));
        check_value("stall", 32'h0, 32'(stall));
        check_value("exc_pending", 32'h0, 32'(exc_pending));
        check_value("epc", 32'h0, epc);
        check_value("cause", 32'h0, 32'(cause));
        finish_test("reset");

        repeat (500) issue(rand_alu_op());
        finish_test("alu_random");

        repeat (200) begin
            issue(rand_mem_op(1'b1));
            issue(rand_mem_op(1'b0));
        end
        finish_test("load_store");

        stall_mode = 1'b1;
        repeat (200) begin
            case ($urandom_range(0, 2))
                0: issue(rand_alu_op());
                1: issue(rand_mem_op(1'b1));
                default: issue(rand_mem_op(1'b0));
            endcase
        end
        finish_test("stall");

        op = '0;
        op.alu_op = exmem_pkg::ALU_ADD;
        op.src_a = 32'h7fff_ffff;
        op.src_b = 32'h1;
        op.wr_en = 1'b1;
        op.wr_addr = 5'd3;
        fault_case(op);
        op.alu_op = exmem_pkg::ALU_SUB;
        op.src_a = 32'h8000_0000;
        fault_case(op);
        fault_case(mem_op_at(exmem_pkg::MEM_LW, 32'h21, 32'h0));
        fault_case(mem_op_at(exmem_pkg::MEM_LH, 32'h43, 32'h0));
        issue(mem_op_at(exmem_pkg::MEM_SW, 32'h10, 32'h0a0b_0c0d));
        fault_case(mem_op_at(exmem_pkg::MEM_SW, 32'h12, 32'hdead_beef));
        issue(mem_op_at(exmem_pkg::MEM_LW, 32'h10, 32'h0));
        fault_case(mem_op_at(exmem_pkg::MEM_SH, 32'h35, 32'h1234));
        issue(mem_op_at(exmem_pkg::MEM_LW, 32'h34, 32'h0));
        finish_test("exceptions");

        repeat (30) issue(rand_alu_op());
        check_value("exc_pending", 32'h0, 32'(exc_pending));
        finish_test("restart");

        if (expq.size() != 0) begin
            errors++;
            fail_cnt++;
            $display("%0d expected write-backs never arrived", expq.size());
        end
        $display("%0d tests passed, %0d tests failed", pass_cnt, fail_cnt);
        if (fail_cnt == 0 && errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: flist.f
hdl/exmem_pkg.sv
hdl/pipe_ctrl.sv
hdl/alu_exec.sv
hdl/ex_mem_reg.sv
hdl/mem_access.sv
hdl/data_ram.sv
hdl/exmem_top.sv
testbench/exmem_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the exmem testbench with Verilator.
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f flist.f --top-module exmem_tb -o sim_exmem
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/sim_exmem > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "TEST RESULT: FAIL" "$LOG"; then
    exit 1
fi
if ! grep -q "TEST RESULT: PASS" "$LOG"; then
    echo "No result line found in $LOG"
    exit 1
fi
exit 0
